// File: cmac_monitor_top.f
+incdir+include
verilog/mac_stream_pkg.sv
verilog/mac_regs_pkg.sv
verilog/rx_stream_monitor.sv
verilog/tx_stream_monitor.sv
verilog/monitor_csr.sv
verilog/cmac_monitor_top.sv
test/tb_cmac_monitor_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cmac_monitor_top
FILELIST  ?= cmac_monitor_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 --timescale 1ns/100ps
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/tb_cmac_monitor_tasks.svh
`ifndef TB_CMAC_MONITOR_TASKS_SVH
`define TB_CMAC_MONITOR_TASKS_SVH
`default_nettype none

// Inputs change a short delay after the edge, outputs are read there too
task automatic next_cycle();
    @(posedge gt_init_clk);
    #DRIVE_DELAY;
endtask

task automatic count_wait(inout int waited, input string what);
    waited++;
    if (waited > BUS_TIMEOUT) begin
        fail_run($sformatf("No %s handshake within %0d cycles", what, BUS_TIMEOUT));
    end
endtask

task automatic check_data(input reg_data_t actual, input reg_data_t expected, input string what);
    if (actual !== expected) begin
        fail_run($sformatf("[FAIL] t=%0t: %s is 0x%08h, expected 0x%08h",
                           $time, what, actual, expected));
    end
endtask

task automatic check_resp(input resp_e actual, input resp_e expected, input string what);
    if (actual !== expected) begin
        fail_run($sformatf("[FAIL] t=%0t: %s response is %0d, expected %s",
                           $time, what, actual, expected.name()));
    end
endtask

task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
        fail_run($sformatf("[FAIL] t=%0t: %s is %b, expected %b", $time, what, actual, expected));
    end
endtask

task automatic axil_write(input reg_addr_t addr, input reg_data_t data, output resp_e resp);
    logic aw_hit;
    logic w_hit;
    int   waited;
    waited           = 0;
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    // Address and data halves may be taken on different edges
    while (axil_req.awvalid || axil_req.wvalid) begin
        aw_hit = axil_rsp.awready;
        w_hit  = axil_rsp.wready;
        next_cycle();
        if (aw_hit) begin
            axil_req.awvalid = 1'b0;
        end
        if (w_hit) begin
            axil_req.wvalid = 1'b0;
        end
        count_wait(waited, "write address or data");
    end
    while (!axil_rsp.bvalid) begin
        next_cycle();
        count_wait(waited, "write response");
    end
    resp            = axil_rsp.bresp;
    axil_req.bready = 1'b1;
    next_cycle();
    axil_req.bready = 1'b0;
endtask

task automatic axil_read(input reg_addr_t addr, input int hold_cycles,
                         output reg_data_t data, output resp_e resp);
    logic ar_hit;
    int   waited;
    waited           = 0;
    ar_hit           = 1'b0;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    while (!ar_hit) begin
        ar_hit = axil_rsp.arready;
        next_cycle();
        count_wait(waited, "read address");
    end
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) begin
        next_cycle();
        count_wait(waited, "read data");
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    // rready held low, response must not move
    repeat (hold_cycles) begin
        next_cycle();
        check_bit(axil_rsp.rvalid, 1'b1, "rvalid while rready is low");
        check_bit(axil_rsp.arready, 1'b0, "arready while rready is low");
        check_data(axil_rsp.rdata, data, "rdata while rready is low");
    end
    axil_req.rready = 1'b1;
    next_cycle();
    axil_req.rready = 1'b0;
endtask

task automatic check_all_registers(input logic [1:0] status);
    reg_map_e  addr;
    reg_data_t expected;
    reg_data_t data;
    resp_e     resp;
    addr = addr.first();
    repeat (addr.num()) begin
        case (addr)
            REG_STATUS:       expected = reg_data_t'(status);
            REG_RX_PKT:       expected = exp_rx.pkt;
            REG_RX_BEATS:     expected = exp_rx.beats;
            REG_RX_LOST:      expected = exp_rx.lost;
            REG_RX_BAD_FCS:   expected = exp_rx.bad_fcs;
            REG_RX_MAX_PKT:   expected = exp_rx.max_pkt;
            REG_TX_PKT:       expected = exp_tx.pkt;
            REG_TX_BEATS:     expected = exp_tx.beats;
            REG_TX_MAX_PKT:   expected = exp_tx.max_pkt;
            REG_TX_OVERFLOW:  expected = exp_tx.overflow;
            REG_TX_UNDERFLOW: expected = exp_tx.underflow;
            default:          expected = '0;
        endcase
        axil_read(addr, 0, data, resp);
        check_data(data, expected, addr.name());
        check_resp(resp, RESP_OKAY, addr.name());
        addr = addr.next();
    end
endtask

// Bit 0 of the rotating mask low means ready in that cycle
task automatic send_rx_packet(input int len, input logic [31:0] stalls);
    int sent;
    sent = 0;
    while (sent < len) begin
        rx_beat = '{valid: 1'b1, ready: !stalls[0], last: (sent == len - 1), user: 1'b0};
        bad_fcs = fcs_count_t'($random(seed));
        exp_rx.beats   += counter_t'(rx_beat.ready);
        exp_rx.lost    += counter_t'(!rx_beat.ready);
        exp_rx.bad_fcs += counter_t'(bad_fcs);
        sent   += int'(rx_beat.ready);
        stalls  = {stalls[0], stalls[31:1]};
        next_cycle();
    end
    rx_beat     = '0;
    bad_fcs     = '0;
    exp_rx.pkt += 1;
    if (counter_t'(len) > exp_rx.max_pkt) begin
        exp_rx.max_pkt = counter_t'(len);
    end
endtask

task automatic send_tx_packet(input int len, input logic [31:0] stalls);
    int sent;
    sent = 0;
    while (sent < len) begin
        tx_beat = '{valid: 1'b1, ready: !stalls[0], last: (sent == len - 1), user: 1'b0};
        {tx_unfout, tx_ovfout} = 2'($random(seed));
        exp_tx.beats     += counter_t'(tx_beat.ready);
        exp_tx.overflow  += counter_t'(tx_ovfout);
        exp_tx.underflow += counter_t'(tx_unfout);
        sent   += int'(tx_beat.ready);
        stalls  = {stalls[0], stalls[31:1]};
        next_cycle();
    end
    tx_beat     = '0;
    tx_ovfout   = 1'b0;
    tx_unfout   = 1'b0;
    exp_tx.pkt += 1;
    if (counter_t'(len) > exp_tx.max_pkt) begin
        exp_tx.max_pkt = counter_t'(len);
    end
endtask

`default_nettype wire
`endif

// File: test/tb_cmac_monitor_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cmac_monitor_top;

    import mac_stream_pkg::*;
    import mac_regs_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int SYNC_STAGES = 3;
    localparam int BUS_TIMEOUT = 50;
    localparam int NUM_PACKETS = 6;
    localparam int MAX_LEN     = 8;
    // Worst case 32 cycles per beat on both streams plus about 60 bus accesses of 12 cycles
    localparam int TEST_CYCLES = 2 * NUM_PACKETS * MAX_LEN * 32 + 60 * 12 + 100;

    logic         gt_init_clk;
    logic         rst_n;
    stream_beat_t rx_beat;
    fcs_count_t   bad_fcs;
    stream_beat_t tx_beat;
    logic         tx_ovfout;
    logic         tx_unfout;
    logic         qsfp_fault_in;
    logic         cmac_rx_aligned;
    axil_req_t    axil_req;
    axil_rsp_t    axil_rsp;
    logic         qsfp_fault_indication;
    logic         cmac_rx_aligned_indication;

    integer       seed;
    // Counter values tallied from the driven stimulus
    rx_counters_t exp_rx;
    tx_counters_t exp_tx;

    cmac_monitor_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_cmac_monitor_top (.*);

    initial begin
        gt_init_clk = 1'b0;
        forever #(CLK_PERIOD / 2) gt_init_clk = ~gt_init_clk;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $fatal(1);
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic test_reset_state();
        check_bit(qsfp_fault_indication, 1'b0, "qsfp_fault_indication after reset");
        check_bit(cmac_rx_aligned_indication, 1'b0, "cmac_rx_aligned_indication after reset");
        check_bit(axil_rsp.awready, 1'b1, "awready after reset");
        check_bit(axil_rsp.wready, 1'b1, "wready after reset");
        check_bit(axil_rsp.arready, 1'b1, "arready after reset");
        check_bit(axil_rsp.bvalid, 1'b0, "bvalid after reset");
        check_bit(axil_rsp.rvalid, 1'b0, "rvalid after reset");
        check_all_registers(2'b00);
    endtask

    task automatic test_rx_counting();
        repeat (NUM_PACKETS) begin
            send_rx_packet(1 + int'($unsigned($random(seed)) % MAX_LEN),
                           $random(seed) & $random(seed) & ~32'h1);
        end
        check_all_registers(2'b00);
    endtask

    task automatic test_tx_counting();
        repeat (NUM_PACKETS) begin
            send_tx_packet(1 + int'($unsigned($random(seed)) % MAX_LEN),
                           $random(seed) & $random(seed) & ~32'h1);
        end
        check_all_registers(2'b00);
    endtask

    task automatic test_back_pressure();
        reg_data_t data;
        resp_e     resp;
        counter_t  beats_before;
        beats_before = exp_rx.beats;
        // Receive beats keep arriving while the read response is held
        fork
            axil_read(REG_RX_BEATS, 6, data, resp);
            begin
                next_cycle();
                send_rx_packet(4, 32'h0);
            end
        join
        check_data(data, beats_before, "REG_RX_BEATS under back-pressure");
        check_resp(resp, RESP_OKAY, "REG_RX_BEATS under back-pressure");
    endtask

    task automatic test_clear();
        reg_data_t data;
        resp_e     resp;
        axil_write(REG_CTRL, 32'h1, resp);
        check_resp(resp, RESP_OKAY, "write to REG_CTRL");
        exp_rx = '0;
        exp_tx = '0;
        check_all_registers(2'b00);
        axil_write(REG_RX_PKT, 32'h5, resp);
        check_resp(resp, RESP_SLVERR, "write to REG_RX_PKT");
        axil_read(reg_addr_t'(6'h30), 0, data, resp);
        check_data(data, '0, "read of unmapped 0x30");
        check_resp(resp, RESP_SLVERR, "read of unmapped 0x30");
    endtask

    task automatic test_status_sync();
        reg_data_t data;
        resp_e     resp;
        int        waited;
        qsfp_fault_in   = 1'b1;
        cmac_rx_aligned = 1'b1;
        waited          = 0;
        while (!(qsfp_fault_indication && cmac_rx_aligned_indication) &&
               waited <= SYNC_STAGES) begin
            next_cycle();
            waited++;
        end
        check_bit(qsfp_fault_indication, 1'b1, "qsfp_fault_indication");
        check_bit(cmac_rx_aligned_indication, 1'b1, "cmac_rx_aligned_indication");
        axil_read(REG_STATUS, 0, data, resp);
        check_data(data, 32'd3, "REG_STATUS");
        check_resp(resp, RESP_OKAY, "REG_STATUS");
    endtask

    initial begin
        seed            = 99;
        exp_rx          = '0;
        exp_tx          = '0;
        rst_n           = 1'b0;
        rx_beat         = '0;
        bad_fcs         = '0;
        tx_beat         = '0;
        tx_ovfout       = 1'b0;
        tx_unfout       = 1'b0;
        qsfp_fault_in   = 1'b0;
        cmac_rx_aligned = 1'b0;
        axil_req        = '0;
        repeat (2) @(posedge gt_init_clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        next_cycle();

        test_reset_state();
        test_rx_counting();
        test_tx_counting();
        test_back_pressure();
        test_clear();
        test_status_sync();

        $display("Simulation completed successfully");
        $finish;
    end

    `include "tb_cmac_monitor_tasks.svh"

endmodule

`default_nettype wire

// File: verilog/cmac_monitor_top.sv
`timescale 1ns/100ps
`default_nettype none

module cmac_monitor_top #(
    parameter int SYNC_STAGES = 3
) (
    input  wire                           gt_init_clk,
    input  wire                           rst_n,

    // MAC receive side
    input  wire mac_stream_pkg::stream_beat_t rx_beat,
    input  wire mac_stream_pkg::fcs_count_t   bad_fcs,

    // MAC send side
    input  wire mac_stream_pkg::stream_beat_t tx_beat,
    input  wire                           tx_ovfout,
    input  wire                           tx_unfout,

    // Asynchronous status levels
    input  wire                           qsfp_fault_in,
    input  wire                           cmac_rx_aligned,

    input  wire mac_regs_pkg::axil_req_t  axil_req,
    output wire mac_regs_pkg::axil_rsp_t  axil_rsp,

    output wire                           qsfp_fault_indication,
    output wire                           cmac_rx_aligned_indication
);

    import mac_regs_pkg::*;

    rx_counters_t rx_counters;
    tx_counters_t tx_counters;
    logic         counter_clear;

    rx_stream_monitor i_rx_stream_monitor (
        .gt_init_clk   (gt_init_clk),
        .rst_n         (rst_n),
        .rx_beat       (rx_beat),
        .bad_fcs       (bad_fcs),
        .counter_clear (counter_clear),
        .rx_counters   (rx_counters)
    );

    tx_stream_monitor i_tx_stream_monitor (
        .gt_init_clk   (gt_init_clk),
        .rst_n         (rst_n),
        .tx_beat       (tx_beat),
        .tx_ovfout     (tx_ovfout),
        .tx_unfout     (tx_unfout),
        .counter_clear (counter_clear),
        .tx_counters   (tx_counters)
    );

    monitor_csr #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_monitor_csr (
        .gt_init_clk                (gt_init_clk),
        .rst_n                      (rst_n),
        .axil_req                   (axil_req),
        .axil_rsp                   (axil_rsp),
        .rx_counters                (rx_counters),
        .tx_counters                (tx_counters),
        .qsfp_fault_in              (qsfp_fault_in),
        .cmac_rx_aligned            (cmac_rx_aligned),
        .counter_clear              (counter_clear),
        .qsfp_fault_indication      (qsfp_fault_indication),
        .cmac_rx_aligned_indication (cmac_rx_aligned_indication)
    );

endmodule

`default_nettype wire

// File: verilog/monitor_csr.sv
`timescale 1ns/100ps
`default_nettype none

module monitor_csr #(
    parameter int SYNC_STAGES = 3
) (
    input  wire                         gt_init_clk,
    input  wire                         rst_n,
    input  wire mac_regs_pkg::axil_req_t axil_req,
    output mac_regs_pkg::axil_rsp_t     axil_rsp,
    input  wire mac_regs_pkg::rx_counters_t rx_counters,
    input  wire mac_regs_pkg::tx_counters_t tx_counters,
    input  wire                         qsfp_fault_in,
    input  wire                         cmac_rx_aligned,
    output logic                        counter_clear,
    output logic                        qsfp_fault_indication,
    output logic                        cmac_rx_aligned_indication
);

    import mac_regs_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,
        ST_RRESP
    } state_e;

    state_e     state;
    logic       aw_taken;
    logic       w_taken;
    reg_addr_t  awaddr_q;
    reg_data_t  wdata_q;
    logic [3:0] wstrb_q;
    resp_e      bresp_q;
    reg_data_t  rdata_q;
    resp_e      rresp_q;

    logic       awready;
    logic       wready;
    logic       arready;
    logic       aw_fire;
    logic       w_fire;
    logic       ar_fire;
    logic       wr_done;
    logic       wr_start;
    logic       wr_clear;
    reg_addr_t  wr_addr;
    reg_data_t  wr_data;
    logic [3:0] wr_strb;
    resp_e      wr_resp;
    reg_data_t  rd_data;
    resp_e      rd_resp;

    logic [SYNC_STAGES-1:0][1:0] sync_q;
    logic       fault_sync;
    logic       aligned_sync;

    assign awready = (state == ST_IDLE) && !aw_taken;
    assign wready  = (state == ST_IDLE) && !w_taken;
    assign arready = (state == ST_IDLE);

    assign aw_fire = axil_req.awvalid && awready;
    assign w_fire  = axil_req.wvalid && wready;
    assign ar_fire = axil_req.arvalid && arready;

    // Either half may already be held from an earlier cycle
    assign wr_addr = aw_taken ? awaddr_q : axil_req.awaddr;
    assign wr_data = w_taken ? wdata_q : axil_req.wdata;
    assign wr_strb = w_taken ? wstrb_q : axil_req.wstrb;
    assign wr_done = (aw_taken || aw_fire) && (w_taken || w_fire);

    // Reads go first when both arrive together
    assign wr_start = (state == ST_IDLE) && wr_done && !ar_fire;

    assign wr_clear = (wr_addr == REG_CTRL) && wr_data[0] && wr_strb[0];
    assign wr_resp  = (wr_addr == REG_CTRL) ? RESP_OKAY : RESP_SLVERR;

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            REG_CTRL:         rd_data = '0;
            REG_STATUS:       rd_data = reg_data_t'({aligned_sync, fault_sync});
            REG_RX_PKT:       rd_data = rx_counters.pkt;
            REG_RX_BEATS:     rd_data = rx_counters.beats;
            REG_RX_LOST:      rd_data = rx_counters.lost;
            REG_RX_BAD_FCS:   rd_data = rx_counters.bad_fcs;
            REG_RX_MAX_PKT:   rd_data = rx_counters.max_pkt;
            REG_TX_PKT:       rd_data = tx_counters.pkt;
            REG_TX_BEATS:     rd_data = tx_counters.beats;
            REG_TX_MAX_PKT:   rd_data = tx_counters.max_pkt;
            REG_TX_OVERFLOW:  rd_data = tx_counters.overflow;
            REG_TX_UNDERFLOW: rd_data = tx_counters.underflow;
            default:          rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            aw_taken      <= 1'b0;
            w_taken       <= 1'b0;
            counter_clear <= 1'b0;
        end else begin
            counter_clear <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (aw_fire) begin
                        aw_taken <= 1'b1;
                    end
                    if (w_fire) begin
                        w_taken <= 1'b1;
                    end
                    if (ar_fire) begin
                        state <= ST_RRESP;
                    end else if (wr_done) begin
                        aw_taken      <= 1'b0;
                        w_taken       <= 1'b0;
                        counter_clear <= wr_clear;
                        state         <= ST_WRESP;
                    end
                end
                ST_WRESP: begin
                    if (axil_req.bready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RRESP: begin
                    if (axil_req.rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge gt_init_clk) begin
        if (aw_fire) begin
            awaddr_q <= axil_req.awaddr;
        end
        if (w_fire) begin
            wdata_q <= axil_req.wdata;
            wstrb_q <= axil_req.wstrb;
        end
        if (wr_start) begin
            bresp_q <= wr_resp;
        end
        // Read data is frozen here and held until rready
        if (ar_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    // Bit 0 fault, bit 1 aligned
    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], {cmac_rx_aligned, qsfp_fault_in}};
        end
    end

    assign fault_sync   = sync_q[SYNC_STAGES-1][0];
    assign aligned_sync = sync_q[SYNC_STAGES-1][1];

    assign qsfp_fault_indication      = fault_sync;
    assign cmac_rx_aligned_indication = aligned_sync;

    always_comb begin
        axil_rsp.awready = awready;
        axil_rsp.wready  = wready;
        axil_rsp.bvalid  = (state == ST_WRESP);
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = (state == ST_RRESP);
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

endmodule

`default_nettype wire

// File: verilog/tx_stream_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module tx_stream_monitor (
    input  wire                          gt_init_clk,
    input  wire                          rst_n,
    input  wire mac_stream_pkg::stream_beat_t tx_beat,
    input  wire                          tx_ovfout,
    input  wire                          tx_unfout,
    input  wire                          counter_clear,
    output mac_regs_pkg::tx_counters_t   tx_counters
);

    import mac_stream_pkg::*;

    logic     beat_fire;
    logic     last_fire;
    counter_t cur_len;
    counter_t pkt_len;

    assign beat_fire = tx_beat.valid && tx_beat.ready;
    assign last_fire = beat_fire && tx_beat.last;
    assign pkt_len   = cur_len + counter_t'(1);

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_counters <= '0;
            cur_len     <= '0;
        end else if (counter_clear) begin
            tx_counters <= '0;
            cur_len     <= '0;
        end else begin
            if (beat_fire) begin
                tx_counters.beats <= tx_counters.beats + counter_t'(1);
            end

            if (last_fire) begin
                tx_counters.pkt <= tx_counters.pkt + counter_t'(1);
                cur_len         <= '0;
                if (pkt_len > tx_counters.max_pkt) begin
                    tx_counters.max_pkt <= pkt_len;
                end
            end else if (beat_fire) begin
                cur_len <= pkt_len;
            end

            // One count per cycle the MAC holds the flag
            if (tx_ovfout) begin
                tx_counters.overflow <= tx_counters.overflow + counter_t'(1);
            end
            if (tx_unfout) begin
                tx_counters.underflow <= tx_counters.underflow + counter_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rx_stream_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module rx_stream_monitor (
    input  wire                          gt_init_clk,
    input  wire                          rst_n,
    input  wire mac_stream_pkg::stream_beat_t rx_beat,
    input  wire mac_stream_pkg::fcs_count_t   bad_fcs,
    input  wire                          counter_clear,
    output mac_regs_pkg::rx_counters_t   rx_counters
);

    import mac_stream_pkg::*;

    logic     beat_fire;
    logic     last_fire;
    logic     beat_lost;
    counter_t cur_len;
    counter_t pkt_len;

    assign beat_fire = rx_beat.valid && rx_beat.ready;
    assign last_fire = beat_fire && rx_beat.last;
    // MAC presented a beat that the sink could not take
    assign beat_lost = rx_beat.valid && !rx_beat.ready;

    // Length of the packet if this beat closes it
    assign pkt_len = cur_len + counter_t'(1);

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_counters <= '0;
            cur_len     <= '0;
        end else if (counter_clear) begin
            rx_counters <= '0;
            cur_len     <= '0;
        end else begin
            if (beat_fire) begin
                rx_counters.beats <= rx_counters.beats + counter_t'(1);
            end

            if (beat_lost) begin
                rx_counters.lost <= rx_counters.lost + counter_t'(1);
            end

            rx_counters.bad_fcs <= rx_counters.bad_fcs + counter_t'(bad_fcs);

            if (last_fire) begin
                rx_counters.pkt <= rx_counters.pkt + counter_t'(1);
                cur_len         <= '0;
                if (pkt_len > rx_counters.max_pkt) begin
                    rx_counters.max_pkt <= pkt_len;
                end
            end else if (beat_fire) begin
                cur_len <= pkt_len;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mac_regs_pkg.sv
`default_nettype none

package mac_regs_pkg;

    typedef logic [5:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Byte addresses of the register map
    typedef enum reg_addr_t {
        REG_CTRL         = 6'h00,
        REG_STATUS       = 6'h04,
        REG_RX_PKT       = 6'h08,
        REG_RX_BEATS     = 6'h0C,
        REG_RX_LOST      = 6'h10,
        REG_RX_BAD_FCS   = 6'h14,
        REG_RX_MAX_PKT   = 6'h18,
        REG_TX_PKT       = 6'h1C,
        REG_TX_BEATS     = 6'h20,
        REG_TX_MAX_PKT   = 6'h24,
        REG_TX_OVERFLOW  = 6'h28,
        REG_TX_UNDERFLOW = 6'h2C
    } reg_map_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } resp_e;

    // Master-driven AXI4-Lite signals
    typedef struct packed {
        logic      awvalid;
        reg_addr_t awaddr;
        logic      wvalid;
        reg_data_t wdata;
        logic [3:0] wstrb;
        logic      bready;
        logic      arvalid;
        reg_addr_t araddr;
        logic      rready;
    } axil_req_t;

    // Slave-driven AXI4-Lite signals
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        resp_e     bresp;
        logic      arready;
        logic      rvalid;
        reg_data_t rdata;
        resp_e     rresp;
    } axil_rsp_t;

    typedef struct packed {
        mac_stream_pkg::counter_t pkt;
        mac_stream_pkg::counter_t beats;
        mac_stream_pkg::counter_t lost;
        mac_stream_pkg::counter_t bad_fcs;
        mac_stream_pkg::counter_t max_pkt;
    } rx_counters_t;

    typedef struct packed {
        mac_stream_pkg::counter_t pkt;
        mac_stream_pkg::counter_t beats;
        mac_stream_pkg::counter_t max_pkt;
        mac_stream_pkg::counter_t overflow;
        mac_stream_pkg::counter_t underflow;
    } tx_counters_t;

endpackage

`default_nettype wire

// File: verilog/mac_stream_pkg.sv
`default_nettype none

package mac_stream_pkg;

    // Observed handshake of one MAC user stream
    // Data and keep are not carried, the monitors only watch the handshake
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
        logic user;
    } stream_beat_t;

    // Bad-FCS events the MAC flags in a single cycle, 0 to 7
    typedef logic [2:0] fcs_count_t;

    // Statistics counter, free running and wraps around
    typedef logic [31:0] counter_t;

endpackage

`default_nettype wire
